// File: build.f
src/ll_stream_pkg.sv
src/mac_pkg.sv
src/fifo36_to_ll8.sv
src/ll8_to_txmac.sv
src/rxmac_to_ll8.sv
src/ll8_to_fifo36.sv
src/gemac_client_top.sv
sim/gemac_client_sva.sv
sim/tb_gemac_client.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_gemac_client -o Vtb_gemac_client -f build.f

./obj_dir/Vtb_gemac_client 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation PASSED"

// File: sim/gemac_client_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks bound to the top level, active outside reset only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gemac_client_sva import ll_stream_pkg::*, mac_pkg::*; (
   input logic      clk,
   input logic      rst_n_i,
   input tx_mac_t   tx_mac_o,
   input logic      tx_ack_i,
   input f36_word_t rx_f36_o,
   input logic      rx_f36_src_rdy_o,
   input logic      rx_f36_dst_rdy_i
);

   logic in_frame_q;
   logic ack_seen_q;
   logic rx_take;

   assign rx_take = rx_f36_src_rdy_o && rx_f36_dst_rdy_i;

   // Error word has eof set, so it closes the frame too
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         in_frame_q <= 1'b0;
      end else if (rx_take) begin
         in_frame_q <= !rx_f36_o.eof;
      end
   end

   // First byte waits on the MAC until the ack
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_seen_q <= 1'b0;
      end else if (!tx_mac_o.valid) begin
         ack_seen_q <= 1'b0;
      end else if (tx_ack_i) begin
         ack_seen_q <= 1'b1;
      end
   end

   a_rx_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      (rx_f36_src_rdy_o && !rx_f36_dst_rdy_i) |=> (rx_f36_src_rdy_o && $stable(rx_f36_o)))
      else $error("rx_f36_o changed while stalled");

   a_tx_first_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      (tx_mac_o.valid && !ack_seen_q && !tx_ack_i) |=>
      (tx_mac_o.valid && $stable(tx_mac_o.data)))
      else $error("tx first byte changed before the ack");

   a_tx_strobes: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(tx_mac_o.valid && tx_mac_o.error))
      else $error("tx valid and error high together");

   a_rx_sof_first: assert property (@(posedge clk) disable iff (!rst_n_i)
      (rx_take && rx_f36_o.eof) |-> (in_frame_q || rx_f36_o.sof))
      else $error("rx eof word without a prior sof");

endmodule

bind gemac_client_top gemac_client_sva u_gemac_client_sva (.*);

// File: sim/tb_gemac_client.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for both chains. Inputs change on the falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_gemac_client import ll_stream_pkg::*, mac_pkg::*; ();

   localparam logic [31:0] SEED = 32'h744322f1;
   // Eighteen frames of at most 23 bytes and a few pauses fit well inside this
   localparam int MAX_CYCLES = 4000;

   logic      clk;
   logic      rst_n_i;
   f36_word_t tx_f36_i;
   logic      tx_f36_src_rdy_i;
   logic      tx_f36_dst_rdy_o;
   tx_mac_t   tx_mac_o;
   logic      tx_ack_i;
   rx_mac_t   rx_mac_i;
   f36_word_t rx_f36_o;
   logic      rx_f36_src_rdy_o;
   logic      rx_f36_dst_rdy_i;

   logic [31:0] stim_seed;
   logic [31:0] rx_seed;
   logic [31:0] mac_seed;
   logic [31:0] rdy_seed;
   logic [7:0]  tx_got[$];
   int          tx_len[$];
   bit          tx_err[$];
   logic [7:0]  tx_exp[$];
   int          tx_exp_len[$];
   bit          tx_exp_err[$];
   f36_word_t   rx_got[$];
   f36_word_t   rx_exp[$];
   bit          rx_hold;
   bit          rx_rand;
   bit          rx_busy;
   bit          fail_seen = 1'b0;
   bit          run_done = 1'b0;
   int          cycles = 0;

   gemac_client_top u_gemac_client_top (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int tx_rand_len();
      stim_seed = lcg_next(stim_seed);
      return 5 + int'(stim_seed[30:16]) % 19;
   endfunction

   function automatic int rx_rand_len();
      rx_seed = lcg_next(rx_seed);
      return 5 + int'(rx_seed[30:16]) % 19;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Test failed");
      fail_seen = 1'b1;
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [35:0] got,
                            input logic [35:0] exp);
      assert (got === exp) else
         stop_run($sformatf("FAILED at %0t ns: %s got %0h expected %0h",
                            $time, name, got, exp));
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         stop_run($sformatf("Timeout after %0d cycles, tests did not finish", cycles));
      end
   end

   // Sim exit through an assertion still ends in the fail message
   final begin
      if (!run_done && !fail_seen) $display("Test failed");
   end

   // Transmit MAC model: ack after a random delay, then one byte per cycle
   initial begin
      int phase;
      int delay;
      int cur_len;
      phase    = 0;
      delay    = 0;
      cur_len  = 0;
      tx_ack_i = 1'b0;
      wait (rst_n_i === 1'b1);
      forever begin
         @(negedge clk);
         tx_ack_i = 1'b0;
         if (phase == 0) begin
            assert (tx_mac_o.error !== 1'b1) else
               stop_run("Transmit error strobe seen outside a frame");
            if (tx_mac_o.valid) begin
               mac_seed = lcg_next(mac_seed);
               delay    = int'(mac_seed[17:16]);
               phase    = 1;
            end
         end
         if (phase == 1) begin
            if (delay == 0) begin
               tx_ack_i = 1'b1;
               tx_got.push_back(tx_mac_o.data);
               cur_len = 1;
               phase   = 2;
            end else begin
               delay--;
            end
         end else if (phase == 2) begin
            if (tx_mac_o.valid) begin
               tx_got.push_back(tx_mac_o.data);
               cur_len++;
            end else begin
               tx_len.push_back(cur_len);
               tx_err.push_back(tx_mac_o.error);
               phase = 0;
            end
         end
      end
   end

   // Receive collector, random stalls only between frames
   initial begin
      rx_f36_dst_rdy_i = 1'b1;
      wait (rst_n_i === 1'b1);
      forever begin
         @(negedge clk);
         rdy_seed = lcg_next(rdy_seed);
         if (rx_hold) rx_f36_dst_rdy_i = 1'b0;
         else if (rx_rand && !rx_busy) rx_f36_dst_rdy_i = rdy_seed[20];
         else rx_f36_dst_rdy_i = 1'b1;
         @(posedge clk);
         if (rx_f36_src_rdy_o && rx_f36_dst_rdy_i) rx_got.push_back(rx_f36_o);
      end
   end

   // Words of len random bytes, with a pause after pause_after words
   task automatic send_tx_frame(input int len, input int pause_after);
      logic [7:0] b [0:23];
      f36_word_t  word;
      int         keep;
      int         nw;
      int         w;
      int         j;
      // Underrun cuts the frame where the words stop
      keep = (pause_after > 0) ? 4 * pause_after : len;
      for (j = 0; j < 24; j++) begin
         stim_seed = lcg_next(stim_seed);
         b[j] = stim_seed[23:16];
         if (j < keep) tx_exp.push_back(b[j]);
      end
      tx_exp_len.push_back(keep);
      tx_exp_err.push_back(pause_after > 0);
      nw = (len + 3) / 4;
      for (w = 0; w < nw; w++) begin
         if (pause_after > 0 && w == pause_after) begin
            tx_f36_src_rdy_i = 1'b0;
            repeat (16) @(negedge clk);
         end
         for (j = 0; j < 4; j++) begin
            word.data[31 - 8 * j -: 8] = (4 * w + j < len) ? b[4 * w + j] : 8'h00;
         end
         word.sof = (w == 0);
         word.eof = (w == nw - 1);
         word.occ = word.eof ? len[1:0] : 2'd0;
         tx_f36_i         = word;
         tx_f36_src_rdy_i = 1'b1;
         @(posedge clk);
         while (!tx_f36_dst_rdy_o) @(posedge clk);
         @(negedge clk);
      end
      tx_f36_src_rdy_i = 1'b0;
   endtask

   task automatic check_tx();
      int n;
      int k;
      int i;
      bit e;
      while (tx_len.size() < tx_exp_len.size()) @(negedge clk);
      while (tx_exp_len.size() > 0) begin
         n = tx_exp_len.pop_front();
         e = tx_exp_err.pop_front();
         k = tx_len.pop_front();
         check_val("tx_mac_o.error", tx_err.pop_front(), e);
         check_val("tx frame length", k, n);
         for (i = 0; i < n; i++) begin
            check_val("tx_mac_o.data", tx_got.pop_front(), tx_exp.pop_front());
         end
      end
   endtask

   // kind 0 good, 1 error strobe, 2 overrun
   task automatic send_rx_frame(input int len, input int kind);
      logic [7:0] b [0:23];
      f36_word_t  word;
      int         nb;
      int         nw;
      int         w;
      int         j;
      for (j = 0; j < 24; j++) begin
         rx_seed = lcg_next(rx_seed);
         b[j] = rx_seed[23:16];
      end
      nb = (kind == 1) ? len - 1 : len;
      nw = (kind == 0) ? (nb + 3) / 4 : nb / 4;
      if (kind == 2) nw = 1;
      for (w = 0; w < nw; w++) begin
         for (j = 0; j < 4; j++) begin
            word.data[31 - 8 * j -: 8] = (4 * w + j < nb) ? b[4 * w + j] : 8'h00;
         end
         word.sof = (w == 0);
         word.eof = (kind == 0) && (w == nw - 1);
         word.occ = word.eof ? nb[1:0] : 2'd0;
         rx_exp.push_back(word);
      end
      if (kind != 0) rx_exp.push_back(F36_ERROR);
      rx_busy = 1'b1;
      @(negedge clk);
      for (j = 0; j < len; j++) begin
         rx_mac_i = '{valid: 1'b1, ack: 1'b0, error: 1'b0, data: b[j]};
         @(negedge clk);
      end
      rx_mac_i = '{valid: 1'b0, ack: (kind != 1), error: (kind == 1), data: 8'h00};
      @(negedge clk);
      rx_mac_i = '0;
      rx_busy  = 1'b0;
      repeat (3) @(negedge clk);
   endtask

   task automatic check_rx();
      f36_word_t   got;
      f36_word_t   exp;
      logic [31:0] mask;
      while (rx_got.size() < rx_exp.size()) @(negedge clk);
      repeat (4) @(negedge clk);
      check_val("rx word count", rx_got.size(), rx_exp.size());
      while (rx_exp.size() > 0) begin
         got = rx_got.pop_front();
         exp = rx_exp.pop_front();
         if (f36_is_error(exp)) begin
            check_val("rx_f36_o.sof/eof", {got.sof, got.eof}, 2'b11);
         end else begin
            check_val("rx_f36_o.sof", got.sof, exp.sof);
            check_val("rx_f36_o.eof", got.eof, exp.eof);
            check_val("rx_f36_o.occ", got.occ, exp.occ);
            mask = (exp.eof && exp.occ != 2'd0) ? ~(32'hffffffff >> (8 * exp.occ))
                                                : 32'hffffffff;
            check_val("rx_f36_o.data", got.data & mask, exp.data & mask);
         end
      end
   endtask

   task automatic tx_good_frames();
      send_tx_frame(tx_rand_len(), 0);
      send_tx_frame(tx_rand_len(), 0);
      check_tx();
   endtask

   task automatic tx_underrun();
      send_tx_frame(16, 2);
      send_tx_frame(tx_rand_len(), 0);
      check_tx();
   endtask

   task automatic rx_good_frames();
      send_rx_frame(rx_rand_len(), 0);
      send_rx_frame(rx_rand_len(), 0);
      check_rx();
   endtask

   task automatic rx_error_frame();
      send_rx_frame(rx_rand_len(), 1);
      send_rx_frame(rx_rand_len(), 0);
      check_rx();
   endtask

   task automatic rx_overrun();
      rx_hold = 1'b1;
      repeat (2) @(negedge clk);
      send_rx_frame(12, 2);
      rx_hold = 1'b0;
      send_rx_frame(rx_rand_len(), 0);
      check_rx();
   endtask

   task automatic mixed_traffic();
      int i;
      rx_rand = 1'b1;
      fork
         for (i = 0; i < 4; i++) send_tx_frame(tx_rand_len(), 0);
         repeat (4) send_rx_frame(rx_rand_len(), 0);
      join
      check_tx();
      check_rx();
      rx_rand = 1'b0;
   endtask

   initial begin
      rst_n_i          = 1'b0;
      tx_f36_i         = '0;
      tx_f36_src_rdy_i = 1'b0;
      rx_mac_i         = '0;
      rx_hold          = 1'b0;
      rx_rand          = 1'b0;
      rx_busy          = 1'b0;
      stim_seed        = SEED;
      rx_seed          = lcg_next(SEED);
      mac_seed         = lcg_next(rx_seed);
      rdy_seed         = lcg_next(mac_seed);
      repeat (10) @(negedge clk);
      rst_n_i = 1'b1;
      check_val("tx_mac_o.valid", tx_mac_o.valid, 1'b0);
      check_val("tx_mac_o.error", tx_mac_o.error, 1'b0);
      check_val("rx_f36_src_rdy_o", rx_f36_src_rdy_o, 1'b0);
      check_val("tx_f36_dst_rdy_o", tx_f36_dst_rdy_o, 1'b1);
      tx_good_frames();
      tx_underrun();
      rx_good_frames();
      rx_error_frame();
      rx_overrun();
      mixed_traffic();
      run_done = 1'b1;
      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: src/fifo36_to_ll8.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered byte output. An error word leaves as one error marker byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fifo36_to_ll8 import ll_stream_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   input  f36_word_t f36_i,
   input  logic      f36_src_rdy_i,
   output logic      f36_dst_rdy_o,
   output ll8_byte_t ll_o,
   output logic      ll_src_rdy_o,
   input  logic      ll_dst_rdy_i
);

   f36_word_t  word_q;
   logic       word_vld_q;
   logic [1:0] idx_q;
   logic [2:0] word_cnt;
   logic       word_last;
   logic       slot_free;
   logic       f36_take;

   // Byte idx of word w, counted from the top
   function automatic ll8_byte_t pick_byte(f36_word_t w, logic [1:0] idx);
      logic [3:0][7:0] bytes;
      logic [2:0]      cnt;
      ll8_byte_t       b;
      bytes  = w.data;
      cnt    = f36_byte_count(w);
      b.data = bytes[2'd3 - idx];
      b.sof  = w.sof && (idx == 2'd0);
      b.eof  = w.eof && ({1'b0, idx} == cnt - 3'd1);
      return b;
   endfunction

   assign word_cnt  = f36_byte_count(word_q);
   assign word_last = ({1'b0, idx_q} == word_cnt - 3'd1);
   assign slot_free = !ll_src_rdy_o || ll_dst_rdy_i;

   // Next word is taken while the last byte of the current one goes out
   assign f36_dst_rdy_o = !word_vld_q || (slot_free && word_last);
   assign f36_take      = f36_src_rdy_i && f36_dst_rdy_o;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         word_vld_q   <= 1'b0;
         idx_q        <= 2'd0;
         ll_src_rdy_o <= 1'b0;
      end else if (slot_free) begin
         if (word_vld_q) begin
            ll_src_rdy_o <= 1'b1;
            if (!word_last) begin
               idx_q <= idx_q + 2'd1;
            end else begin
               idx_q      <= 2'd0;
               word_vld_q <= f36_take;
            end
         end else if (f36_take) begin
            // First byte bypasses the word register
            ll_src_rdy_o <= 1'b1;
            word_vld_q   <= (f36_byte_count(f36_i) != 3'd1);
            idx_q        <= 2'd1;
         end else begin
            ll_src_rdy_o <= 1'b0;
         end
      end else if (f36_take) begin
         word_vld_q <= 1'b1;
         idx_q      <= 2'd0;
      end
   end

   always_ff @(posedge clk) begin
      if (f36_take) word_q <= f36_i;
      if (slot_free) begin
         if (word_vld_q) ll_o <= pick_byte(word_q, idx_q);
         else if (f36_take) ll_o <= pick_byte(f36_i, 2'd0);
      end
   end

endmodule

// File: src/gemac_client_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Client side of the MAC in one clock domain, no FIFOs between stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gemac_client_top import ll_stream_pkg::*, mac_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   // Transmit client words
   input  f36_word_t tx_f36_i,
   input  logic      tx_f36_src_rdy_i,
   output logic      tx_f36_dst_rdy_o,
   // Transmit MAC
   output tx_mac_t   tx_mac_o,
   input  logic      tx_ack_i,
   // Receive MAC
   input  rx_mac_t   rx_mac_i,
   // Receive client words
   output f36_word_t rx_f36_o,
   output logic      rx_f36_src_rdy_o,
   input  logic      rx_f36_dst_rdy_i
);

   ll8_byte_t tx_ll;
   logic      tx_ll_src_rdy;
   logic      tx_ll_dst_rdy;
   ll8_byte_t rx_ll;
   logic      rx_ll_src_rdy;
   logic      rx_ll_dst_rdy;

   // Transmit chain
   fifo36_to_ll8 u_fifo36_to_ll8 (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .f36_i         (tx_f36_i),
      .f36_src_rdy_i (tx_f36_src_rdy_i),
      .f36_dst_rdy_o (tx_f36_dst_rdy_o),
      .ll_o          (tx_ll),
      .ll_src_rdy_o  (tx_ll_src_rdy),
      .ll_dst_rdy_i  (tx_ll_dst_rdy)
   );

   ll8_to_txmac u_ll8_to_txmac (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .ll_i         (tx_ll),
      .ll_src_rdy_i (tx_ll_src_rdy),
      .ll_dst_rdy_o (tx_ll_dst_rdy),
      .tx_o         (tx_mac_o),
      .tx_ack_i     (tx_ack_i)
   );

   // Receive chain
   rxmac_to_ll8 u_rxmac_to_ll8 (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .rx_i         (rx_mac_i),
      .ll_o         (rx_ll),
      .ll_src_rdy_o (rx_ll_src_rdy),
      .ll_dst_rdy_i (rx_ll_dst_rdy)
   );

   ll8_to_fifo36 u_ll8_to_fifo36 (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .ll_i          (rx_ll),
      .ll_src_rdy_i  (rx_ll_src_rdy),
      .ll_dst_rdy_o  (rx_ll_dst_rdy),
      .f36_o         (rx_f36_o),
      .f36_src_rdy_o (rx_f36_src_rdy_o),
      .f36_dst_rdy_i (rx_f36_dst_rdy_i)
   );

endmodule

// File: src/ll8_to_fifo36.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One output word of buffering. An error marker flushes the partial word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ll8_to_fifo36 import ll_stream_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   input  ll8_byte_t ll_i,
   input  logic      ll_src_rdy_i,
   output logic      ll_dst_rdy_o,
   output f36_word_t f36_o,
   output logic      f36_src_rdy_o,
   input  logic      f36_dst_rdy_i
);

   logic [23:0] acc_q;
   logic [1:0]  cnt_q;
   logic        wsof_q;
   logic        take;
   logic        word_done;
   logic        cur_sof;
   logic [31:0] shifted;
   logic [31:0] word_data;

   assign ll_dst_rdy_o = !f36_src_rdy_o || f36_dst_rdy_i;
   assign take         = ll_src_rdy_i && ll_dst_rdy_o;
   assign word_done    = take && (ll_i.eof || (cnt_q == 2'd3));

   // Word takes its sof from the first byte
   assign cur_sof = (cnt_q == 2'd0) ? ll_i.sof : wsof_q;

   // Left-align a short last word so the first byte lands on top
   assign shifted   = {acc_q, ll_i.data};
   assign word_data = shifted << {2'd3 - cnt_q, 3'b000};

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         cnt_q         <= 2'd0;
         wsof_q        <= 1'b0;
         f36_src_rdy_o <= 1'b0;
      end else begin
         if (word_done) f36_src_rdy_o <= 1'b1;
         else if (f36_dst_rdy_i) f36_src_rdy_o <= 1'b0;

         if (take) begin
            wsof_q <= cur_sof;
            if (word_done) cnt_q <= 2'd0;
            else cnt_q <= cnt_q + 2'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) acc_q <= {acc_q[15:0], ll_i.data};

      if (word_done) begin
         if (ll8_is_error(ll_i)) begin
            f36_o <= F36_ERROR;
         end else begin
            // occ wraps to 0 on a full word
            f36_o <= '{occ:  ll_i.eof ? cnt_q + 2'd1 : 2'd0,
                       eof:  ll_i.eof,
                       sof:  cur_sof,
                       data: word_data};
         end
      end
   end

endmodule

// File: src/ll8_to_txmac.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte stream must keep up after the ack or the frame is cut with error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ll8_to_txmac import ll_stream_pkg::*, mac_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   input  ll8_byte_t ll_i,
   input  logic      ll_src_rdy_i,
   output logic      ll_dst_rdy_o,
   output tx_mac_t   tx_o,
   input  logic      tx_ack_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_ACK,
      ST_SEND,
      ST_DROP
   } state_t;

   state_t    state_q;
   ll8_byte_t cur_q;
   logic      valid_q;
   logic      err_q;
   logic      take;

   // Byte on the MAC leaves on the ack, then one per cycle
   always_comb begin
      case (state_q)
         ST_IDLE:     ll_dst_rdy_o = 1'b1;
         ST_WAIT_ACK: ll_dst_rdy_o = tx_ack_i && !cur_q.eof;
         ST_SEND:     ll_dst_rdy_o = !cur_q.eof;
         default:     ll_dst_rdy_o = 1'b1;
      endcase
   end

   assign take = ll_src_rdy_i && ll_dst_rdy_o;
   assign tx_o = '{valid: valid_q, error: err_q, data: cur_q.data};

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         valid_q <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         err_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               // Bytes outside a frame are dropped
               if (take && ll_i.sof && !ll8_is_error(ll_i)) begin
                  state_q <= ST_WAIT_ACK;
                  valid_q <= 1'b1;
               end
            end
            ST_WAIT_ACK, ST_SEND: begin
               if (tx_ack_i || (state_q == ST_SEND)) begin
                  if (cur_q.eof) begin
                     valid_q <= 1'b0;
                     state_q <= ST_IDLE;
                  end else if (!ll_src_rdy_i) begin
                     valid_q <= 1'b0;
                     err_q   <= 1'b1;
                     state_q <= ST_DROP;
                  end else if (ll8_is_error(ll_i)) begin
                     // Marker ends the frame itself
                     valid_q <= 1'b0;
                     err_q   <= 1'b1;
                     state_q <= ST_IDLE;
                  end else begin
                     state_q <= ST_SEND;
                  end
               end
            end
            default: begin
               if (take && ll_i.eof) state_q <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) cur_q <= ll_i;
   end

endmodule

// File: src/ll_stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Client word and byte formats. A frame is always longer than four bytes
// So a word or byte with both sof and eof set can mark an errored frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ll_stream_pkg;

   // First byte of the word sits in data[31:24]
   typedef struct packed {
      logic [1:0]  occ;    // Valid bytes on an eof word, 0 means all four
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } f36_word_t;

   typedef struct packed {
      logic       sof;
      logic       eof;
      logic [7:0] data;
   } ll8_byte_t;

   localparam f36_word_t F36_ERROR = '{occ: 2'd0, eof: 1'b1, sof: 1'b1, data: 32'd0};
   localparam ll8_byte_t LL8_ERROR = '{sof: 1'b1, eof: 1'b1, data: 8'd0};

   function automatic logic f36_is_error(f36_word_t w);
      return w.sof && w.eof;
   endfunction

   // Number of bytes a word carries onto the byte stream
   function automatic logic [2:0] f36_byte_count(f36_word_t w);
      if (f36_is_error(w)) return 3'd1;
      if (w.eof && (w.occ != 2'd0)) return {1'b0, w.occ};
      return 3'd4;
   endfunction

   function automatic logic ll8_is_error(ll8_byte_t b);
      return b.sof && b.eof;
   endfunction

endpackage

// File: src/mac_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte strobes between the client adapters and the gigabit MAC core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mac_pkg;

   // Toward the transmit MAC
   // valid is held from the first byte to the last
   // error replaces valid for one cycle on underrun
   typedef struct packed {
      logic       valid;
      logic       error;
      logic [7:0] data;
   } tx_mac_t;

   // From the receive MAC
   // valid on consecutive cycles, one byte each
   // ack or error pulses once on the cycle after the last byte
   typedef struct packed {
      logic       valid;
      logic       ack;
      logic       error;
      logic [7:0] data;
   } rx_mac_t;

endpackage

// File: src/rxmac_to_ll8.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// No back-pressure to the MAC. A stalled output overruns the frame
// Bad and overrun frames end in one error marker byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module rxmac_to_ll8 import ll_stream_pkg::*, mac_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   input  rx_mac_t   rx_i,
   output ll8_byte_t ll_o,
   output logic      ll_src_rdy_o,
   input  logic      ll_dst_rdy_i
);

   ll8_byte_t hold_q;
   logic      hold_vld_q;
   logic      ovr_q;
   logic      err_pend_q;
   logic      sof_next_q;
   logic      out_free;
   logic      mark_load;
   logic      hold_move;
   logic      overrun;
   logic      frame_end;

   assign frame_end = rx_i.ack || rx_i.error;
   assign out_free  = !ll_src_rdy_o || ll_dst_rdy_i;

   // Pending marker wins the output slot
   assign mark_load = out_free && err_pend_q;

   // Held byte leaves once its successor or the ack shows up
   assign hold_move = hold_vld_q && out_free && !err_pend_q && !rx_i.error &&
                      (hold_q.eof || rx_i.valid || rx_i.ack);

   assign overrun = rx_i.valid && !ovr_q && hold_vld_q && !(out_free && !err_pend_q);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         hold_vld_q   <= 1'b0;
         ovr_q        <= 1'b0;
         err_pend_q   <= 1'b0;
         sof_next_q   <= 1'b1;
         ll_src_rdy_o <= 1'b0;
      end else begin
         if (mark_load || hold_move) ll_src_rdy_o <= 1'b1;
         else if (ll_dst_rdy_i) ll_src_rdy_o <= 1'b0;

         if (mark_load) err_pend_q <= 1'b0;
         if (overrun || (rx_i.error && !ovr_q)) err_pend_q <= 1'b1;

         // Rest of an overrun frame is dropped up to its end strobe
         if (overrun) ovr_q <= 1'b1;
         else if (frame_end) ovr_q <= 1'b0;

         if (rx_i.valid && !ovr_q && !overrun) hold_vld_q <= 1'b1;
         else if (hold_move || overrun || rx_i.error) hold_vld_q <= 1'b0;

         if (frame_end) sof_next_q <= 1'b1;
         else if (rx_i.valid) sof_next_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rx_i.valid) hold_q <= '{sof: sof_next_q, eof: 1'b0, data: rx_i.data};
      else if (rx_i.ack) hold_q.eof <= 1'b1;

      if (mark_load) begin
         ll_o <= LL8_ERROR;
      end else if (hold_move) begin
         ll_o <= '{sof: hold_q.sof, eof: hold_q.eof || rx_i.ack, data: hold_q.data};
      end
   end

endmodule
